/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SRCS      ?= $(shell grep -v '^+' $(FILELIST)) include/core_defs.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/alu.sv */
/*
  Integer ALU
  Add, subtract, logic, compares and shifts, plus an equality flag
*/
module alu import riscv_core_pkg::*; (
  input  alu_req_t req_i,
  output word_t    result_o,
  output logic     equal_o
);

  logic [4:0] shamt;

  // Shift amount from the low five bits
  assign shamt = req_i.b[4:0];

  always_comb begin
    unique case (req_i.op)
      ALU_ADD:  result_o = req_i.a + req_i.b;
      ALU_SUB:  result_o = req_i.a - req_i.b;
      ALU_AND:  result_o = req_i.a & req_i.b;
      ALU_OR:   result_o = req_i.a | req_i.b;
      ALU_XOR:  result_o = req_i.a ^ req_i.b;
      // Compares give 0 or 1
      ALU_SLT:  result_o = word_t'($signed(req_i.a) < $signed(req_i.b));
      ALU_SLTU: result_o = word_t'(req_i.a < req_i.b);
      ALU_SLL:  result_o = req_i.a << shamt;
      ALU_SRL:  result_o = req_i.a >> shamt;
      ALU_SRA:  result_o = word_t'($signed(req_i.a) >>> shamt);
      default:  result_o = '0;
    endcase
  end

  // BEQ and BNE
  assign equal_o = (req_i.a == req_i.b);

endmodule

/* hdl/core_top.sv */
/*
  RV32I core top level
  Fetch, decode, ALU and load store unit with the busy flag
*/
module core_top import riscv_core_pkg::*; (
  input  logic  clk,
  input  logic  rst_ni,
  input  word_t boot_addr_i,
  input  logic  fetch_enable_i,
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output word_t instr_addr_o,
  input  word_t instr_rdata_i,
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i,
  output logic  core_busy_o
);

  fetch_t   fetch;
  alu_req_t alu_req;
  lsu_req_t lsu_req;
  word_t    target, alu_result, lsu_rdata;
  logic     fetch_valid, fetch_ready, pc_set, alu_equal;
  logic     lsu_req_valid, lsu_done, ctrl_active, if_busy, lsu_busy;

  //////////////////////////////////////////////////
  // Busy flag
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_o <= 1'b0;
    end else begin
      core_busy_o <= ctrl_active | if_busy | lsu_busy;
    end
  end

  if_stage if_stage_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .pc_set_i       ( pc_set         ),
    .target_i       ( target         ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_o        ( fetch          ),
    .fetch_ready_i  ( fetch_ready    ),
    .busy_o         ( if_busy        )
  );

  id_stage id_stage_i (
    .clk             ( clk            ),
    .rst_ni          ( rst_ni         ),
    .fetch_enable_i  ( fetch_enable_i ),
    .fetch_valid_i   ( fetch_valid    ),
    .fetch_i         ( fetch          ),
    .fetch_ready_o   ( fetch_ready    ),
    .pc_set_o        ( pc_set         ),
    .target_o        ( target         ),
    .boot_addr_i     ( boot_addr_i    ),
    .alu_req_o       ( alu_req        ),
    .alu_result_i    ( alu_result     ),
    .alu_equal_i     ( alu_equal      ),
    .lsu_req_valid_o ( lsu_req_valid  ),
    .lsu_req_o       ( lsu_req        ),
    .lsu_done_i      ( lsu_done       ),
    .lsu_rdata_i     ( lsu_rdata      ),
    .ctrl_active_o   ( ctrl_active    )
  );

  alu alu_i (
    .req_i    ( alu_req    ),
    .result_o ( alu_result ),
    .equal_o  ( alu_equal  )
  );

  load_store_unit load_store_unit_i (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .req_valid_i   ( lsu_req_valid ),
    .req_i         ( lsu_req       ),
    .done_o        ( lsu_done      ),
    .rdata_o       ( lsu_rdata     ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rdata_i  ( data_rdata_i  ),
    .busy_o        ( lsu_busy      )
  );

endmodule

/* hdl/id_stage.sv */
/*
  Decode stage
  Decoder, operand muxes, branch decision, controller FSM and writeback
*/
module id_stage import riscv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     fetch_enable_i,
  input  logic     fetch_valid_i,
  input  fetch_t   fetch_i,
  output logic     fetch_ready_o,
  output logic     pc_set_o,
  output word_t    target_o,
  input  word_t    boot_addr_i,
  output alu_req_t alu_req_o,
  input  word_t    alu_result_i,
  input  logic     alu_equal_i,
  output logic     lsu_req_valid_o,
  output lsu_req_t lsu_req_o,
  input  logic     lsu_done_i,
  input  word_t    lsu_rdata_i,
  output logic     ctrl_active_o
);

  ctrl_state_e state_q, state_d;
  word_t       instr, pc, imm_i, imm_s, imm_b, imm_j, imm_u;
  word_t       rdata_a, rdata_b, wdata;
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic        decoding, accept, is_mem, is_jal, taken, rd_we;
  alu_op_e     alu_op;

  //////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////
  assign instr  = fetch_i.instr;
  assign pc     = fetch_i.pc;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  assign is_mem = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
  assign is_jal = (opcode == OPC_JAL);
  // BEQ and BNE only, other compares fall through
  assign taken  = (opcode == OPC_BRANCH) &&
                  (((funct3 == 3'b000) && alu_equal_i) || ((funct3 == 3'b001) && !alu_equal_i));
  assign rd_we  = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) || (opcode == OPC_LUI) ||
                  (opcode == OPC_LOAD) || is_jal;

  // funct3 to ALU op, SUB only for register form
  always_comb begin
    unique case (funct3)
      3'b000:  alu_op = ((opcode == OPC_OP) && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  // Operand select, address add shares the ALU
  always_comb begin
    alu_req_o.op = ALU_ADD;
    alu_req_o.a  = rdata_a;
    alu_req_o.b  = rdata_b;
    case (opcode)
      OPC_OP:     alu_req_o.op = alu_op;
      OPC_OP_IMM: begin
        alu_req_o.op = alu_op;
        alu_req_o.b  = imm_i;
      end
      OPC_LUI: begin
        alu_req_o.a = '0;
        alu_req_o.b = imm_u;
      end
      OPC_LOAD:   alu_req_o.b = imm_i;
      OPC_STORE:  alu_req_o.b = imm_s;
      default:    ;
    endcase
  end

  //////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CTRL_RESET: if (fetch_enable_i) state_d = CTRL_BOOT;
      default:    state_d = CTRL_DECODE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  assign decoding      = (state_q == CTRL_DECODE);
  assign ctrl_active_o = (state_q != CTRL_RESET);
  // Memory ops hold until the LSU finishes
  assign fetch_ready_o = decoding & (~is_mem | lsu_done_i);
  assign accept        = fetch_valid_i & fetch_ready_o;

  assign pc_set_o = (state_q == CTRL_BOOT) | (accept & (is_jal | taken));
  assign target_o = (state_q == CTRL_BOOT) ? boot_addr_i : pc + (is_jal ? imm_j : imm_b);

  assign lsu_req_valid_o = decoding & fetch_valid_i & is_mem;
  assign lsu_req_o.we    = (opcode == OPC_STORE);
  assign lsu_req_o.addr  = alu_result_i;
  assign lsu_req_o.wdata = rdata_b;

  // Writeback source
  always_comb begin
    if (opcode == OPC_LOAD) begin
      wdata = lsu_rdata_i;
    end else if (is_jal) begin
      wdata = pc + word_t'(4);
    end else begin
      wdata = alu_result_i;
    end
  end

  register_file register_file_i (
    .clk       ( clk            ),
    .rst_ni    ( rst_ni         ),
    .raddr_a_i ( instr[19:15]   ),
    .raddr_b_i ( instr[24:20]   ),
    .rdata_a_o ( rdata_a        ),
    .rdata_b_o ( rdata_b        ),
    .we_i      ( accept & rd_we ),
    .waddr_i   ( instr[11:7]    ),
    .wdata_i   ( wdata          )
  );

  // No redirect while a load or store is in flight
  assert property (@(posedge clk) disable iff (!rst_ni)
    lsu_req_valid_o && !lsu_done_i |=> !pc_set_o);

endmodule

/* hdl/if_stage.sv */
/*
  Instruction fetch stage
  Fetch PC, instruction port handshake and a one-entry fetch buffer
*/
`include "core_defs.svh"

module if_stage import riscv_core_pkg::*; (
  input  logic   clk,
  input  logic   rst_ni,
  input  logic   pc_set_i,
  input  word_t  target_i,
  output logic   instr_req_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  output word_t  instr_addr_o,
  input  word_t  instr_rdata_i,
  output logic   fetch_valid_o,
  output fetch_t fetch_o,
  input  logic   fetch_ready_i,
  output logic   busy_o
);

  word_t  next_pc_q, addr_q, tag_pc_q;
  logic   fetch_on_q, wait_q, out_q, drop_q, req_stale_q, buf_valid_q;
  fetch_t buf_q;
  logic   consume, can_issue, grant;

  // Buffer slot frees up when ID takes the entry
  assign consume   = buf_valid_q & fetch_ready_i;
  assign can_issue = fetch_on_q & ~out_q & (~buf_valid_q | consume) & ~pc_set_i;
  // Ungranted request stays up
  assign instr_req_o  = wait_q | can_issue;
  assign instr_addr_o = wait_q ? addr_q : next_pc_q;
  assign grant        = instr_req_o & instr_gnt_i;

  assign fetch_valid_o = buf_valid_q;
  assign fetch_o       = buf_q;
  assign busy_o        = out_q | wait_q;

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      next_pc_q   <= '0;
      fetch_on_q  <= 1'b0;
      wait_q      <= 1'b0;
      out_q       <= 1'b0;
      drop_q      <= 1'b0;
      req_stale_q <= 1'b0;
      buf_valid_q <= 1'b0;
      buf_q       <= '{instr: `NOP_INSTR, pc: '0};
    end else begin
      wait_q <= instr_req_o & ~instr_gnt_i;
      // Redirect during a held request, its response is junk
      req_stale_q <= instr_req_o & ~instr_gnt_i & (pc_set_i | req_stale_q);
      if (pc_set_i) begin
        fetch_on_q <= 1'b1;
        next_pc_q  <= target_i;
      end else if (grant && !req_stale_q) begin
        next_pc_q <= instr_addr_o + word_t'(4);
      end
      // Outstanding response and its drop flag
      if (grant) begin
        out_q  <= 1'b1;
        drop_q <= pc_set_i | req_stale_q;
      end else if (instr_rvalid_i) begin
        out_q  <= 1'b0;
        drop_q <= 1'b0;
      end else if (pc_set_i && out_q) begin
        drop_q <= 1'b1;
      end
      if (pc_set_i) begin
        buf_valid_q <= 1'b0;
      end else if (instr_rvalid_i && !drop_q) begin
        buf_valid_q <= 1'b1;
        buf_q       <= '{instr: instr_rdata_i, pc: tag_pc_q};
      end else if (consume) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Address capture, only read while held or tagging
  always_ff @(posedge clk) begin
    addr_q <= instr_addr_o;
    if (grant) begin
      tag_pc_q <= instr_addr_o;
    end
  end

  // Held request keeps its address until grant
  assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

/* hdl/load_store_unit.sv */
/*
  Load store unit
  Word requests on the data port with grant and response valid
*/
module load_store_unit import riscv_core_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  lsu_req_t req_i,
  output logic     done_o,
  output word_t    rdata_o,
  output logic     data_req_o,
  input  logic     data_gnt_i,
  input  logic     data_rvalid_i,
  output logic     data_we_o,
  output word_t    data_addr_o,
  output word_t    data_wdata_o,
  input  word_t    data_rdata_i,
  output logic     busy_o
);

  lsu_state_e state_q, state_d;

  // ID holds the request steady until done
  assign data_req_o   = ((state_q == LSU_IDLE) & req_valid_i) | (state_q == LSU_WAIT_GNT);
  assign data_we_o    = data_req_o & req_i.we;
  assign data_addr_o  = req_i.addr;
  assign data_wdata_o = req_i.wdata;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      LSU_IDLE: begin
        if (req_valid_i) state_d = data_gnt_i ? LSU_WAIT_RVALID : LSU_WAIT_GNT;
      end
      LSU_WAIT_GNT: begin
        if (data_gnt_i) state_d = LSU_WAIT_RVALID;
      end
      default: begin
        if (data_rvalid_i) state_d = LSU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // One-cycle done, load data rides along
  assign done_o  = (state_q == LSU_WAIT_RVALID) & data_rvalid_i;
  assign rdata_o = data_rdata_i;
  assign busy_o  = (state_q != LSU_IDLE);

  // Memory must not answer without a granted request
  assert property (@(posedge clk) disable iff (!rst_ni)
    state_q == LSU_IDLE |-> !data_rvalid_i);

endmodule

/* hdl/register_file.sv */
/*
  Integer register file
  31 writable registers, two read ports, x0 reads zero
*/
`include "core_defs.svh"

module register_file import riscv_core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs_q [1:`NREGS-1];

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `NREGS; i++) regs_q[i] <= '0;
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 hardwired
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* hdl/riscv_core_pkg.sv */
/*
  Core type package
  Word and index types, opcodes, FSM encodings and stage structs
*/
`include "core_defs.svh"

package riscv_core_pkg;

  typedef logic [`XLEN-1:0]   word_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [6:0]         opcode_t;

  // Major opcodes of the supported subset
  localparam opcode_t OPC_OP     = 7'h33;
  localparam opcode_t OPC_OP_IMM = 7'h13;
  localparam opcode_t OPC_LUI    = 7'h37;
  localparam opcode_t OPC_LOAD   = 7'h03;
  localparam opcode_t OPC_STORE  = 7'h23;
  localparam opcode_t OPC_BRANCH = 7'h63;
  localparam opcode_t OPC_JAL    = 7'h6f;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  typedef enum logic [1:0] {CTRL_RESET, CTRL_BOOT, CTRL_DECODE} ctrl_state_e;

  typedef enum logic [1:0] {LSU_IDLE, LSU_WAIT_GNT, LSU_WAIT_RVALID} lsu_state_e;

  // IF to ID
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_t;

  // ID to ALU
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
  } alu_req_t;

  // ID to LSU
  typedef struct packed {
    logic  we;
    word_t addr;
    word_t wdata;
  } lsu_req_t;

endpackage

/* include/core_defs.svh */
/*
  Core configuration
  Datapath width, register file size and the fetch reset word
*/
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and address width
`define XLEN 32

// Architectural registers, x0 included
`define NREGS 32
`define REG_AW 5

// ADDI x0, x0, 0 held in the fetch buffer out of reset
`define NOP_INSTR 32'h0000_0013

`endif

/* sources.f */
+incdir+include
hdl/riscv_core_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/if_stage.sv
hdl/load_store_unit.sv
hdl/id_stage.sv
hdl/core_top.sv
verification/core_mem_model.sv
verification/tb_core_top.sv

/* verification/core_mem_model.sv */
/*
  Memory model for the core testbench
  Instruction and data ports with random grant and response delays
*/
module core_mem_model import riscv_core_pkg::*; (
  input  logic  clk,
  input  logic  rst_ni,
  input  logic  instr_req_i,
  output logic  instr_gnt_o,
  output logic  instr_rvalid_o,
  input  word_t instr_addr_i,
  output word_t instr_rdata_o,
  input  logic  data_req_i,
  output logic  data_gnt_o,
  output logic  data_rvalid_o,
  input  logic  data_we_i,
  input  word_t data_addr_i,
  input  word_t data_wdata_i,
  output word_t data_rdata_o
);

  word_t       imem [word_t];
  word_t       dmem [word_t];
  logic [31:0] rng;
  // Per port: grant countdown, pending response and its countdown
  int          i_gwait, i_rwait, d_gwait, d_rwait;
  logic        i_pend, d_pend;
  word_t       i_addr, d_addr;

  task automatic write_instr(input word_t addr, input word_t word);
    imem[addr] = word;
  endtask

  task automatic write_data(input word_t addr, input word_t word);
    dmem[addr] = word;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Grant 0 to 3 cycles, response 1 to 3 cycles
  task automatic draw_delays(output int gwait, output int rwait);
    rng   = xorshift32(rng);
    rwait = 1 + int'(rng % 32'd3);
    rng   = xorshift32(rng);
    gwait = int'(rng % 32'd4);
  endtask

  // Unloaded words decode as custom-0 and retire as no-ops
  function automatic word_t instr_at(input word_t addr);
    if (imem.exists(addr)) begin
      return imem[addr];
    end else begin
      return {addr[31:7] ^ addr[24:0], 7'h0b};
    end
  endfunction

  function automatic word_t data_at(input word_t addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end else begin
      return addr ^ 32'h5a5a_a5a5;
    end
  endfunction

  initial begin
    rng            = 32'ha464_bc13;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    data_gnt_o     = 1'b0;
    data_rvalid_o  = 1'b0;
    data_rdata_o   = '0;
    i_pend         = 1'b0;
    d_pend         = 1'b0;
    i_gwait        = 0;
    d_gwait        = 0;
    i_rwait        = 0;
    d_rwait        = 0;
    forever begin
      @(posedge clk);
      // Handshakes completed at this edge
      if (!rst_ni) begin
        i_pend = 1'b0;
        d_pend = 1'b0;
      end else begin
        if (instr_rvalid_o) i_pend = 1'b0;
        if (instr_req_i && instr_gnt_o) begin
          i_pend = 1'b1;
          i_addr = instr_addr_i;
          draw_delays(i_gwait, i_rwait);
        end else if (instr_req_i && i_gwait > 0) begin
          i_gwait--;
        end
        if (data_rvalid_o) d_pend = 1'b0;
        if (data_req_i && data_gnt_o) begin
          d_pend = 1'b1;
          d_addr = data_addr_i;
          if (data_we_i) dmem[data_addr_i] = data_wdata_i;
          draw_delays(d_gwait, d_rwait);
        end else if (data_req_i && d_gwait > 0) begin
          d_gwait--;
        end
      end
      @(negedge clk);
      // One outstanding transaction per port
      instr_gnt_o    = !i_pend && (i_gwait == 0);
      instr_rvalid_o = i_pend && (i_rwait == 1);
      if (instr_rvalid_o) instr_rdata_o = instr_at(i_addr);
      else if (i_pend) i_rwait--;
      data_gnt_o    = !d_pend && (d_gwait == 0);
      data_rvalid_o = d_pend && (d_rwait == 1);
      if (data_rvalid_o) data_rdata_o = data_at(d_addr);
      else if (d_pend) d_rwait--;
    end
  end

endmodule

/* verification/core_stimulus.txt */
# Columns: record tag, hex address, hex word
# P program word, D preloaded data word, E expected store in issue order
P 00000080 00001537
P 00000084 06400093
P 00000088 FF900113
P 0000008C 002081B3
P 00000090 00352023
P 00000094 40110233
P 00000098 00452223
P 0000009C 0020F2B3
P 000000A0 0020E333
P 000000A4 0020C3B3
P 000000A8 00552423
P 000000AC 00652623
P 000000B0 00752823
P 000000B4 00112433
P 000000B8 001134B3
P 000000BC 00852A23
P 000000C0 00952C23
P 000000C4 00400593
P 000000C8 00B11633
P 000000CC 00B156B3
P 000000D0 40B15733
P 000000D4 00C52E23
P 000000D8 02D52023
P 000000DC 02E52223
P 000000E0 ABCDE7B7
P 000000E4 00508013
P 000000E8 02F52423
P 000000EC 02052623
P 000000F0 10052883
P 000000F4 01188913
P 000000F8 03252823
P 000000FC 00208463
P 00000100 02152A23
P 00000104 00209463
P 00000108 02252C23
P 0000010C 00108463
P 00000110 02252C23
P 00000114 00319463
P 00000118 02352C23
P 0000011C 008009EF
P 00000120 02252E23
P 00000124 03352E23
P 00000128 0000006F
D 00001100 12345678
E 00001000 0000005D
E 00001004 FFFFFF95
E 00001008 00000060
E 0000100C FFFFFFFD
E 00001010 FFFFFF9D
E 00001014 00000001
E 00001018 00000000
E 0000101C FFFFFF90
E 00001020 0FFFFFFF
E 00001024 FFFFFFFF
E 00001028 ABCDE000
E 0000102C 00000000
E 00001030 12345689
E 00001034 00000064
E 00001038 0000005D
E 0000103C 00000120

/* verification/tb_core_top.sv */
/*
  Testbench for the RV32I core
  Loads program, data and expected stores from the stimulus file,
  runs the core against a random-latency memory and checks each store
*/
module tb_core_top import riscv_core_pkg::*; ();

  localparam word_t BOOT_ADDR     = 32'h0000_0080;
  localparam int    CYC_PER_INSTR = 80;
  localparam int    QUIET_CYCLES  = 40;

  logic  clk, rst_ni, fetch_enable;
  word_t boot_addr;
  logic  instr_req, instr_gnt, instr_rvalid;
  word_t instr_addr, instr_rdata;
  logic  data_req, data_gnt, data_rvalid, data_we;
  word_t data_addr, data_wdata, data_rdata;
  logic  core_busy;

  // Expected stores in issue order
  word_t exp_addr_q [$];
  word_t exp_data_q [$];
  int    n_prog, n_store, cycles, cycle_limit;

  //////////////////////////////////////////////////
  // DUT and memory
  //////////////////////////////////////////////////
  core_top core_top_i (
    .clk            ( clk          ),
    .rst_ni         ( rst_ni       ),
    .boot_addr_i    ( boot_addr    ),
    .fetch_enable_i ( fetch_enable ),
    .instr_req_o    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  ),
    .data_we_o      ( data_we      ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_rdata_i   ( data_rdata   ),
    .core_busy_o    ( core_busy    )
  );

  core_mem_model core_mem_model_i (
    .clk            ( clk          ),
    .rst_ni         ( rst_ni       ),
    .instr_req_i    ( instr_req    ),
    .instr_gnt_o    ( instr_gnt    ),
    .instr_rvalid_o ( instr_rvalid ),
    .instr_addr_i   ( instr_addr   ),
    .instr_rdata_o  ( instr_rdata  ),
    .data_req_i     ( data_req     ),
    .data_gnt_o     ( data_gnt     ),
    .data_rvalid_o  ( data_rvalid  ),
    .data_we_i      ( data_we      ),
    .data_addr_i    ( data_addr    ),
    .data_wdata_i   ( data_wdata   ),
    .data_rdata_o   ( data_rdata   )
  );

  // 40 unit period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_store_addr(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_store_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_fetch_addr(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  // One record per line with a tag and two hex fields
  task automatic load_stimulus();
    int         fd;
    int         n;
    string      line;
    logic [7:0] tag;
    word_t      a, d;
    fd = $fopen("verification/core_stimulus.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Cannot open verification/core_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%c %h %h", tag, a, d);
        if (n == 3) begin
          case (tag)
            "P": begin
              core_mem_model_i.write_instr(a, d);
              n_prog++;
            end
            "D": core_mem_model_i.write_data(a, d);
            "E": begin
              exp_addr_q.push_back(a);
              exp_data_q.push_back(d);
            end
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Store monitor and timeout
  //////////////////////////////////////////////////
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      if (rst_ni) begin
        cycles++;
        if (cycles > cycle_limit) begin
          stop_with_failure($sformatf("Timeout after %0d cycles with %0d stores still missing",
                                      cycles, exp_addr_q.size()));
        end else if (data_req && data_gnt && data_we) begin
          if (exp_addr_q.size() == 0) begin
            stop_with_failure("The core issued a store after the last expected one");
          end else begin
            check_store_addr($sformatf("store %0d address", n_store), exp_addr_q[0], data_addr);
            check_store_data($sformatf("store %0d data", n_store), exp_data_q[0], data_wdata);
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            n_store++;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    rst_ni       = 1'b0;
    fetch_enable = 1'b0;
    boot_addr    = BOOT_ADDR;
    n_prog       = 0;
    n_store      = 0;
    cycle_limit  = 0;
    load_stimulus();
    cycle_limit = CYC_PER_INSTR * n_prog;
    repeat (3) @(negedge clk);
    rst_ni = 1'b1;
    // Fetch still disabled so both ports idle
    repeat (4) begin
      @(posedge clk);
      check_flag("idle instr_req", 1'b0, instr_req);
      check_flag("idle data_req", 1'b0, data_req);
      check_flag("idle core_busy", 1'b0, core_busy);
    end
    @(negedge clk);
    fetch_enable = 1'b1;
    do begin
      @(posedge clk);
    end while (!instr_req);
    check_fetch_addr("first fetch", BOOT_ADDR, instr_addr);
    while (exp_addr_q.size() != 0) begin
      @(posedge clk);
    end
    // Self-loop reached and no store may follow
    repeat (QUIET_CYCLES) @(posedge clk);
    // Controller left reset so the core reports busy
    check_flag("running core_busy", 1'b1, core_busy);
    $display("TB PASSED");
    $finish;
  end

endmodule
